//--- Makefile
SOURCES := $(shell cat tb.f)

obj_dir/Vcu_setup_tb: tb.f $(SOURCES)
	verilator --binary --timing --assert --Mdir obj_dir --top-module cu_setup_tb -f tb.f

run: obj_dir/Vcu_setup_tb
	./obj_dir/Vcu_setup_tb +verilator+error+limit+100 | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- design/cu_setup_top.sv
`timescale 1ns/1ps
`default_nettype none

module cu_setup_top (
    input  logic                         ap_clk,
    input  logic                         areset_cu_setup,
    input  logic                         desc_valid,
    input  setup_pkg::setup_descriptor_t desc,
    input  logic                         cu_flush,
    input  logic                         response_valid,
    input  logic                         request_ready,
    output logic                         request_valid,
    output setup_pkg::read_request_t     request,
    output logic                         done
);

    import setup_pkg::*;

    // Sequencer and generator
    logic          cmd_start;
    read_cmd_t     cmd;
    logic          gen_idle;

    // Generator and FIFO
    logic          push;
    read_request_t push_data;
    logic          prog_full;
    logic          fifo_empty;

    setup_sequencer u_setup_sequencer (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .desc_valid      (desc_valid),
        .desc            (desc),
        .cu_flush        (cu_flush),
        .response_valid  (response_valid),
        .gen_idle        (gen_idle),
        .fifo_empty      (fifo_empty),
        .cmd_start       (cmd_start),
        .cmd             (cmd),
        .done            (done)
    );

    read_request_gen u_read_request_gen (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .cmd_start       (cmd_start),
        .cmd             (cmd),
        .prog_full       (prog_full),
        .push            (push),
        .push_data       (push_data),
        .gen_idle        (gen_idle)
    );

    request_fifo u_request_fifo (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .push            (push),
        .push_data       (push_data),
        .request_ready   (request_ready),
        .request_valid   (request_valid),
        .request         (request),
        .prog_full       (prog_full),
        .empty           (fifo_empty)
    );

endmodule : cu_setup_top

`default_nettype wire

//--- design/read_request_gen.sv
`timescale 1ns/1ps
`default_nettype none

module read_request_gen (
    input  logic                     ap_clk,
    input  logic                     areset_cu_setup,
    input  logic                     cmd_start,
    input  setup_pkg::read_cmd_t     cmd,
    input  logic                     prog_full,
    output logic                     push,
    output setup_pkg::read_request_t push_data,
    output logic                     gen_idle
);

    import setup_pkg::*;

    count_t count_q;
    count_t index_q;
    logic   flush_q;
    logic   busy;

    // ----------------------------------------------------------
    // Run state
    // ----------------------------------------------------------
    // Busy while words remain, so a zero count is idle at once
    assign busy     = (index_q < count_q);
    assign gen_idle = ~busy;

    // Pause while the FIFO sits at its threshold
    assign push = busy & ~prog_full;

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            count_q <= '0;
            index_q <= '0;
        end else if (cmd_start) begin
            count_q <= cmd.count;
            index_q <= '0;
        end else if (push) begin
            index_q <= index_q + count_t'(1);
        end
    end

    always_ff @(posedge ap_clk) begin
        if (cmd_start) begin
            flush_q <= cmd.flush;
        end
    end

    // ----------------------------------------------------------
    // Request payload
    // ----------------------------------------------------------
    always_comb begin
        push_data.addr  = addr_t'(index_q) << word_shift;
        push_data.flush = flush_q;
    end

endmodule : read_request_gen

`default_nettype wire

//--- design/request_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module request_fifo (
    input  logic                     ap_clk,
    input  logic                     areset_cu_setup,
    input  logic                     push,
    input  setup_pkg::read_request_t push_data,
    input  logic                     request_ready,
    output logic                     request_valid,
    output setup_pkg::read_request_t request,
    output logic                     prog_full,
    output logic                     empty
);

    import setup_pkg::*;

    read_request_t mem [fifo_depth];

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_ptr_t fill;
    logic      pop;

    // ----------------------------------------------------------
    // Status
    // ----------------------------------------------------------
    assign fill      = wr_ptr - rd_ptr;
    assign empty     = (wr_ptr == rd_ptr);
    assign prog_full = (fill >= fifo_ptr_t'(prog_thresh));
    assign pop       = request_ready & ~empty;

    // ----------------------------------------------------------
    // Pointers
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + fifo_ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + fifo_ptr_t'(1);
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr[fifo_addr_w-1:0]] <= push_data;
        end
    end

    // Popped entry shows up one cycle later
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            request_valid <= 1'b0;
        end else begin
            request_valid <= pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (pop) begin
            request <= mem[rd_ptr[fifo_addr_w-1:0]];
        end
    end

endmodule : request_fifo

`default_nettype wire

//--- design/setup_pkg.sv
`default_nettype none

package setup_pkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------
    // Word counts and outstanding response counts
    typedef logic [15:0] count_t;

    // Byte address of one read request
    typedef logic [31:0] addr_t;

    // Index to byte address for 8-byte words
    localparam int word_shift = 3;

    // ----------------------------------------------------------
    // Request FIFO sizing
    // ----------------------------------------------------------
    localparam int fifo_depth  = 16;
    localparam int prog_thresh = 12;
    localparam int fifo_addr_w = $clog2(fifo_depth);

    // Extra bit tells full from empty
    localparam int fifo_ptr_w  = fifo_addr_w + 1;

    typedef logic [fifo_ptr_w-1:0] fifo_ptr_t;

    // ----------------------------------------------------------
    // Bundles
    // ----------------------------------------------------------
    typedef struct packed {
        count_t program_count;
        count_t flush_count;
        logic   flush_enable;
    } setup_descriptor_t;

    typedef struct packed {
        addr_t addr;
        logic  flush;
    } read_request_t;

    // Start command, sequencer to generator
    typedef struct packed {
        count_t count;
        logic   flush;
    } read_cmd_t;

    typedef enum logic [2:0] {
        SETUP_IDLE,
        SETUP_PROG_START,
        SETUP_PROG_BUSY,
        SETUP_PROG_DONE,
        SETUP_FLUSH_START,
        SETUP_FLUSH_BUSY,
        SETUP_DONE
    } setup_state_t;

endpackage : setup_pkg

`default_nettype wire

//--- design/setup_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module setup_sequencer (
    input  logic                         ap_clk,
    input  logic                         areset_cu_setup,
    input  logic                         desc_valid,
    input  setup_pkg::setup_descriptor_t desc,
    input  logic                         cu_flush,
    input  logic                         response_valid,
    input  logic                         gen_idle,
    input  logic                         fifo_empty,
    output logic                         cmd_start,
    output setup_pkg::read_cmd_t         cmd,
    output logic                         done
);

    import setup_pkg::*;

    setup_state_t      state;
    setup_state_t      next_state;
    setup_descriptor_t desc_q;
    count_t            resp_count;
    logic              resp_zero;
    logic              phase_end;

    assign resp_zero = (resp_count == '0);

    // Generator has not picked up the command yet while cmd_start is high
    assign phase_end = gen_idle & resp_zero & fifo_empty & ~cmd_start;

    assign done = (state == SETUP_DONE);

    // ----------------------------------------------------------
    // Descriptor capture
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (state == SETUP_IDLE && desc_valid) begin
            desc_q <= desc;
        end
    end

    // ----------------------------------------------------------
    // Phase state machine
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            state <= SETUP_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            SETUP_IDLE: begin
                if (desc_valid) begin
                    next_state = SETUP_PROG_START;
                end
            end
            SETUP_PROG_START: begin
                next_state = SETUP_PROG_BUSY;
            end
            SETUP_PROG_BUSY: begin
                if (phase_end) begin
                    next_state = SETUP_PROG_DONE;
                end
            end
            SETUP_PROG_DONE: begin
                if (!desc_q.flush_enable) begin
                    next_state = SETUP_DONE;
                end else if (cu_flush) begin
                    next_state = SETUP_FLUSH_START;
                end
            end
            SETUP_FLUSH_START: begin
                next_state = SETUP_FLUSH_BUSY;
            end
            SETUP_FLUSH_BUSY: begin
                if (phase_end) begin
                    next_state = SETUP_DONE;
                end
            end
            // Held until reset
            SETUP_DONE: begin
                next_state = SETUP_DONE;
            end
            default: begin
                next_state = SETUP_IDLE;
            end
        endcase
    end

    // ----------------------------------------------------------
    // Start strobe and response counter
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            cmd_start  <= 1'b0;
            resp_count <= '0;
        end else begin
            cmd_start <= (state == SETUP_PROG_START) || (state == SETUP_FLUSH_START);
            if (state == SETUP_PROG_START) begin
                resp_count <= desc_q.program_count;
            end else if (state == SETUP_FLUSH_START) begin
                resp_count <= desc_q.flush_count;
            end else if (response_valid && !resp_zero) begin
                resp_count <= resp_count - count_t'(1);
            end
        end
    end

    // Command payload valid alongside cmd_start
    always_ff @(posedge ap_clk) begin
        if (state == SETUP_PROG_START) begin
            cmd.count <= desc_q.program_count;
            cmd.flush <= 1'b0;
        end else if (state == SETUP_FLUSH_START) begin
            cmd.count <= desc_q.flush_count;
            cmd.flush <= 1'b1;
        end
    end

endmodule : setup_sequencer

`default_nettype wire

//--- tb.f
design/setup_pkg.sv
design/setup_sequencer.sv
design/read_request_gen.sv
design/request_fifo.sv
design/cu_setup_top.sv
verif/cu_setup_checker.sv
verif/cu_setup_tb.sv

//--- verif/cu_setup_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cu_setup_checker (
    input logic ap_clk,
    input logic areset_cu_setup,
    input logic request_valid,
    input logic done
);

    // Assertion failures so far
    int fail_count = 0;

    // ----------------------------------------------------------
    // Completion rules
    // ----------------------------------------------------------
    // done is sticky until the next reset
    done_holds: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        done |=> done
    ) else begin
        $error("done fell while reset was low");
        fail_count++;
    end

    // All traffic is over once done is up
    no_request_after_done: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        done |-> !request_valid
    ) else begin
        $error("request_valid high while done");
        fail_count++;
    end

    done_low_after_reset: assert property (
        @(posedge ap_clk)
        $fell(areset_cu_setup) |-> !done
    ) else begin
        $error("done high on the first cycle after reset");
        fail_count++;
    end

endmodule : cu_setup_checker

`default_nettype wire

//--- verif/cu_setup_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cu_setup_tb;

    import setup_pkg::*;

    logic              ap_clk = 1'b0;
    logic              areset_cu_setup = 1'b1;
    logic              desc_valid = 1'b0;
    setup_descriptor_t desc = '0;
    logic              cu_flush = 1'b0;
    logic              response_valid = 1'b0;
    logic              request_ready = 1'b0;
    logic              request_valid;
    read_request_t     request;
    logic              done;

    // Run setup owned by the main sequence
    int   exp_prog = 0;
    int   exp_total = 0;
    int   ready_mode = 0;
    logic long_delay = 1'b0;
    logic desc_sent = 1'b0;
    int   timeout_count = 0;

    // Monitor and response model state
    int   cycle = 0;
    int   req_seen = 0;
    int   resp_sent = 0;
    int   error_count = 0;
    int   check_count = 0;
    int   stretch = 0;
    logic ready_low = 1'b0;
    logic done_q = 1'b0;
    int   resp_due[$];

    cu_setup_top u_cu_setup_top (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .desc_valid      (desc_valid),
        .desc            (desc),
        .cu_flush        (cu_flush),
        .response_valid  (response_valid),
        .request_ready   (request_ready),
        .request_valid   (request_valid),
        .request         (request),
        .done            (done)
    );

    bind cu_setup_top cu_setup_checker u_cu_setup_checker (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .request_valid   (request_valid),
        .done            (done)
    );

    always #2 ap_clk = ~ap_clk;

    task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Mismatches, timeouts and assertion failures so far
    function automatic int failure_total();
        return error_count + timeout_count + u_cu_setup_top.u_cu_setup_checker.fail_count;
    endfunction

    // Program words come before flush words and sit 8 bytes apart
    function automatic read_request_t model_request(input int idx);
        read_request_t r;
        if (idx < exp_prog) begin
            r.addr  = addr_t'(idx * 8);
            r.flush = 1'b0;
        end else begin
            r.addr  = addr_t'((idx - exp_prog) * 8);
            r.flush = 1'b1;
        end
        return r;
    endfunction

    // ----------------------------------------------------------
    // Monitor, response model and ready driver
    // ----------------------------------------------------------
    always @(negedge ap_clk) begin
        if (areset_cu_setup) begin
            request_ready  = 1'b0;
            response_valid = 1'b0;
            req_seen       = 0;
            resp_sent      = 0;
            stretch        = 0;
            ready_low      = 1'b0;
            done_q         = 1'b0;
            resp_due.delete();
        end else begin
            if (!desc_sent) begin
                compare(64'(request_valid), 64'd0, "request_valid before descriptor");
                compare(64'(done), 64'd0, "done before descriptor");
            end
            if (done_q) begin
                compare(64'(done), 64'd1, "done fell before reset");
                compare(64'(request_valid), 64'd0, "request after done");
            end
            if (request_valid) begin
                compare(64'(req_seen < exp_total), 64'd1, "request beyond expected count");
                if (req_seen >= exp_prog) begin
                    compare(64'(cu_flush), 64'd1, "flush request before cu_flush");
                end
                compare(64'(request), 64'(model_request(req_seen)), "request contents");
                req_seen++;
                resp_due.push_back(cycle + (long_delay ? 8 : int'($urandom_range(8, 1))));
            end
            if (done && !done_q) begin
                compare(64'(resp_sent), 64'(exp_total), "responses when done rose");
                compare(64'(req_seen), 64'(exp_total), "requests when done rose");
            end
            done_q = done;
            // At most one response strobe per cycle
            response_valid = 1'b0;
            if (resp_due.size() > 0 && resp_due[0] <= cycle) begin
                void'(resp_due.pop_front());
                response_valid = 1'b1;
                resp_sent++;
            end
            case (ready_mode)
                1: begin
                    // Long low stretches with short high bursts
                    if (stretch == 0) begin
                        ready_low = !ready_low;
                        stretch   = ready_low ? int'($urandom_range(60, 20))
                                              : int'($urandom_range(6, 2));
                    end
                    stretch--;
                    request_ready = !ready_low;
                end
                2: request_ready = 1'b1;
                default: request_ready = ($urandom_range(99, 0) < 70);
            endcase
        end
        cycle++;
    end

    // ----------------------------------------------------------
    // Sequence helpers
    // ----------------------------------------------------------
    task automatic reset_dut();
        areset_cu_setup = 1'b1;
        desc_valid      = 1'b0;
        cu_flush        = 1'b0;
        desc_sent       = 1'b0;
        repeat (8) @(negedge ap_clk);
        areset_cu_setup = 1'b0;
    endtask

    task automatic wait_traffic(input int reqs, input int resps, input string what);
        int i;
        for (i = 0; i < 5000; i++) begin
            if (req_seen >= reqs && resp_sent >= resps) break;
            @(negedge ap_clk);
        end
        if (i == 5000) begin
            timeout_count++;
            $display("Timeout after 5000 cycles waiting for %s", what);
        end
    endtask

    task automatic wait_done(input string what);
        int i;
        for (i = 0; i < 5000; i++) begin
            if (done) break;
            @(negedge ap_clk);
        end
        if (i == 5000) begin
            timeout_count++;
            $display("Timeout after 5000 cycles waiting for done in %s", what);
        end
    endtask

    task automatic run_case(input string name, input int prog_n, input int flush_n,
                            input int mode, input logic slow, input logic inject);
        int                errors_before;
        setup_descriptor_t d;
        errors_before = failure_total();
        exp_prog      = prog_n;
        exp_total     = prog_n + flush_n;
        ready_mode    = mode;
        long_delay    = slow;
        reset_dut();
        repeat (5) @(negedge ap_clk);
        d.program_count = count_t'(prog_n);
        d.flush_count   = count_t'(flush_n);
        d.flush_enable  = (flush_n > 0);
        desc            = d;
        desc_valid      = 1'b1;
        desc_sent       = 1'b1;
        @(negedge ap_clk);
        desc_valid = 1'b0;
        if (inject) begin
            wait_traffic(prog_n / 2, 0, "half of the program requests");
            d.program_count = count_t'(prog_n + 7);
            d.flush_count   = 16'd5;
            d.flush_enable  = 1'b1;
            desc            = d;
            desc_valid      = 1'b1;
            @(negedge ap_clk);
            desc_valid = 1'b0;
        end
        if (flush_n > 0) begin
            wait_traffic(prog_n, prog_n, "the program phase");
            // Quiet gap where nothing may come out before cu_flush
            repeat (20) @(negedge ap_clk);
            cu_flush = 1'b1;
        end
        wait_done(name);
        repeat (10) @(negedge ap_clk);
        $display("test %s (program %0d, flush %0d): %0d errors", name, prog_n, flush_n,
                 failure_total() - errors_before);
    endtask

    initial begin
        int errors_before;
        void'($urandom(64));
        run_case("program_only", int'($urandom_range(40, 1)), 0, 0, 1'b0, 1'b0);
        run_case("program_flush", int'($urandom_range(40, 1)), int'($urandom_range(40, 1)),
                 0, 1'b0, 1'b0);
        run_case("back_pressure", int'($urandom_range(40, 30)), int'($urandom_range(40, 20)),
                 1, 1'b0, 1'b0);
        run_case("done_gating", int'($urandom_range(40, 1)), 0, 2, 1'b1, 1'b0);
        run_case("desc_while_busy", int'($urandom_range(40, 20)), 0, 0, 1'b0, 1'b1);

        // Reset after a finished run leaves outputs idle until a descriptor
        errors_before = failure_total();
        exp_prog  = 0;
        exp_total = 0;
        reset_dut();
        repeat (20) @(negedge ap_clk);
        $display("test reset_state: %0d errors", failure_total() - errors_before);

        $display("%0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
                 check_count, error_count, timeout_count,
                 u_cu_setup_top.u_cu_setup_checker.fail_count);
        if (failure_total() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : cu_setup_tb

`default_nettype wire
